/* src/RvcPkg.sv */
package RvcPkg;

  localparam int HalfwordBits = 16;

  // RV32I base opcodes
  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpOp     = 7'b0110011;
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpBranch = 7'b1100011;

  localparam logic [4:0] RegZero = 5'd0;
  localparam logic [4:0] RegRa   = 5'd1;
  localparam logic [4:0] RegSp   = 5'd2;

  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rdRs1;
    logic [4:0] rs2;
    logic [1:0] op;
  } CrFormat;

  typedef struct packed {
    logic [2:0] funct3;
    logic       immHigh; // Bit 12, sign of the immediate
    logic [4:0] rdRs1;
    logic [4:0] immLow;
    logic [1:0] op;
  } CiFormat;

  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rdPrime;
    logic [1:0] op;
  } CiwFormat;

  // cl and cs share one layout, cs also carries the CA arithmetic forms
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] immHigh;
    logic [2:0] rs1Prime;
    logic [1:0] immLow;
    logic [2:0] rdRs2Prime;
    logic [1:0] op;
  } ClsFormat;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] offsetHigh;
    logic [2:0] rs1Prime;
    logic [4:0] offsetLow;
    logic [1:0] op;
  } CbFormat;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  op;
  } CjFormat;

  typedef union packed {
    CrFormat  cr;
    CiFormat  ci;
    CiwFormat ciw;
    ClsFormat cl;
    ClsFormat cs;
    CbFormat  cb;
    CjFormat  cj;
  } CompactFormat;

endpackage

/* src/CompactInstructionsUnit.sv */
`timescale 1ns/100ps

module CompactInstructionsUnit (
  input  logic [31:0] targetInstruction,
  output logic [31:0] resultInstruction,
  output logic        isIllegal,
  output logic        isUnsupported
);

  localparam logic [31:0] Nop = {12'd0, RvcPkg::RegZero, 3'b000, RvcPkg::RegZero, RvcPkg::OpImm};

  RvcPkg::CompactFormat word;

  logic        isCompressed;
  logic [31:0] expandedInstruction;

  logic [4:0]  ciwRd;
  logic [4:0]  clRs1;
  logic [4:0]  clRd;
  logic [4:0]  csRs1;
  logic [4:0]  csRs2;
  logic [4:0]  cbRs1;

  logic [11:0] addi4spnImm;
  logic [11:0] loadImm;
  logic [11:0] storeImm;
  logic [11:0] ciImm;
  logic [19:0] luiImm;
  logic [11:0] addi16spImm;
  logic [11:0] jumpOffset;
  logic [8:0]  branchRaw;
  logic [12:0] branchOffset;
  logic [2:0]  arithSelect;

  assign word = targetInstruction[RvcPkg::HalfwordBits-1:0];
  assign isCompressed = targetInstruction[1:0] != 2'b11;

  // Compressed registers map onto x8..x15
  assign ciwRd = {2'b01, word.ciw.rdPrime};
  assign clRs1 = {2'b01, word.cl.rs1Prime};
  assign clRd  = {2'b01, word.cl.rdRs2Prime};
  assign csRs1 = {2'b01, word.cs.rs1Prime};
  assign csRs2 = {2'b01, word.cs.rdRs2Prime};
  assign cbRs1 = {2'b01, word.cb.rs1Prime};

  assign addi4spnImm = {2'b00, word.ciw.imm[5:2], word.ciw.imm[7:6],
                        word.ciw.imm[0], word.ciw.imm[1], 2'b00};
  assign loadImm  = {5'd0, word.cl.immLow[0], word.cl.immHigh, word.cl.immLow[1], 2'b00};
  assign storeImm = {5'd0, word.cs.immLow[0], word.cs.immHigh, word.cs.immLow[1], 2'b00};
  assign ciImm    = {{7{word.ci.immHigh}}, word.ci.immLow};
  assign luiImm   = {{15{word.ci.immHigh}}, word.ci.immLow};
  assign addi16spImm = {{3{word.ci.immHigh}}, word.ci.immLow[2:1], word.ci.immLow[3],
                        word.ci.immLow[0], word.ci.immLow[4], 4'b0000};

  // offset[11|4|9:8|10|6|7|3:1|5]
  assign jumpOffset = {word.cj.target[10], word.cj.target[6], word.cj.target[8:7],
                       word.cj.target[4], word.cj.target[5], word.cj.target[0],
                       word.cj.target[9], word.cj.target[3:1], 1'b0};

  // offset[8|4:3] and [7:6|2:1|5]
  assign branchRaw = {word.cb.offsetHigh[2], word.cb.offsetLow[4:3], word.cb.offsetLow[0],
                      word.cb.offsetHigh[1:0], word.cb.offsetLow[2:1], 1'b0};
  assign branchOffset = {{4{branchRaw[8]}}, branchRaw};

  assign arithSelect = {word.cb.offsetHigh[2], word.cs.immLow};

  always_comb begin
    expandedInstruction = Nop;
    isIllegal = 1'b0;
    isUnsupported = 1'b0;

    if (isCompressed) begin
      case (word.cr.op)
        2'b00: begin
          case (word.ciw.funct3)
            3'b000: begin // C.ADDI4SPN
              if (word.ciw.imm == 8'd0) begin
                isIllegal = 1'b1; // Includes the all-zero word
              end else begin
                expandedInstruction = {addi4spnImm, RvcPkg::RegSp, 3'b000, ciwRd,
                                       RvcPkg::OpImm};
              end
            end
            3'b010: begin // C.LW
              expandedInstruction = {loadImm, clRs1, 3'b010, clRd, RvcPkg::OpLoad};
            end
            3'b100: isIllegal = 1'b1; // Reserved
            3'b110: begin // C.SW
              expandedInstruction = {storeImm[11:5], csRs2, csRs1, 3'b010, storeImm[4:0],
                                     RvcPkg::OpStore};
            end
            default: isUnsupported = 1'b1; // FP loads and stores, RV64/128
          endcase
        end

        2'b01: begin
          case (word.ci.funct3)
            3'b000: begin // C.ADDI, C.NOP
              expandedInstruction = {ciImm, word.ci.rdRs1, 3'b000, word.ci.rdRs1,
                                     RvcPkg::OpImm};
            end
            3'b001: begin // C.JAL
              expandedInstruction = {jumpOffset[11], jumpOffset[10:1], jumpOffset[11],
                                     {8{jumpOffset[11]}}, RvcPkg::RegRa, RvcPkg::OpJal};
            end
            3'b010: begin // C.LI
              expandedInstruction = {ciImm, RvcPkg::RegZero, 3'b000, word.ci.rdRs1,
                                     RvcPkg::OpImm};
            end
            3'b011: begin
              if ({word.ci.immHigh, word.ci.immLow} == 6'd0) begin
                isIllegal = 1'b1;
              end else if (word.ci.rdRs1 == RvcPkg::RegSp) begin // C.ADDI16SP
                expandedInstruction = {addi16spImm, RvcPkg::RegSp, 3'b000, RvcPkg::RegSp,
                                       RvcPkg::OpImm};
              end else begin // C.LUI
                expandedInstruction = {luiImm, word.ci.rdRs1, RvcPkg::OpLui};
              end
            end
            3'b100: begin
              case (word.cb.offsetHigh[1:0])
                2'b10: begin // C.ANDI
                  expandedInstruction = {ciImm, cbRs1, 3'b111, cbRs1, RvcPkg::OpImm};
                end
                2'b11: begin
                  case (arithSelect)
                    3'b000: begin // C.SUB
                      expandedInstruction = {7'b0100000, csRs2, csRs1, 3'b000, csRs1,
                                             RvcPkg::OpOp};
                    end
                    3'b001: begin // C.XOR
                      expandedInstruction = {7'b0000000, csRs2, csRs1, 3'b100, csRs1,
                                             RvcPkg::OpOp};
                    end
                    3'b010: begin // C.OR
                      expandedInstruction = {7'b0000000, csRs2, csRs1, 3'b110, csRs1,
                                             RvcPkg::OpOp};
                    end
                    3'b011: begin // C.AND
                      expandedInstruction = {7'b0000000, csRs2, csRs1, 3'b111, csRs1,
                                             RvcPkg::OpOp};
                    end
                    3'b100, 3'b101: isUnsupported = 1'b1; // C.SUBW, C.ADDW
                    default: isIllegal = 1'b1;
                  endcase
                end
                default: isUnsupported = 1'b1; // C.SRLI, C.SRAI
              endcase
            end
            3'b101: begin // C.J
              expandedInstruction = {jumpOffset[11], jumpOffset[10:1], jumpOffset[11],
                                     {8{jumpOffset[11]}}, RvcPkg::RegZero, RvcPkg::OpJal};
            end
            3'b110: begin // C.BEQZ
              expandedInstruction = {branchOffset[12], branchOffset[10:5], RvcPkg::RegZero,
                                     cbRs1, 3'b000, branchOffset[4:1], branchOffset[11],
                                     RvcPkg::OpBranch};
            end
            default: begin // C.BNEZ
              expandedInstruction = {branchOffset[12], branchOffset[10:5], RvcPkg::RegZero,
                                     cbRs1, 3'b001, branchOffset[4:1], branchOffset[11],
                                     RvcPkg::OpBranch};
            end
          endcase
        end

        2'b10: begin
          // Only C.ADD is expanded in this quadrant
          if (word.cr.funct4 == 4'b1001 && word.cr.rs2 != RvcPkg::RegZero) begin
            expandedInstruction = {7'b0000000, word.cr.rs2, word.cr.rdRs1, 3'b000,
                                   word.cr.rdRs1, RvcPkg::OpOp};
          end else begin
            isUnsupported = 1'b1;
          end
        end

        default: begin
        end
      endcase
    end
  end

  // Flagged encodings leave the expansion at the NOP
  always_comb begin
    if (!isCompressed) begin
      resultInstruction = targetInstruction;
    end else begin
      resultInstruction = expandedInstruction;
    end
  end

endmodule

/* src/InstructionAligner.sv */
`timescale 1ns/100ps

module InstructionAligner #(
  parameter logic [31:0] ResetVector = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetchValid,
  input  logic [31:0] fetchWord,
  input  logic        redirectValid,
  input  logic [31:0] redirectAddress,
  output logic        slot0Valid,
  output logic [31:0] slot0Raw,
  output logic [31:0] slot0Address,
  output logic        slot1Valid,
  output logic [31:0] slot1Raw,
  output logic [31:0] slot1Address
);

  localparam int Half = RvcPkg::HalfwordBits;

  logic [31:0]     nextAddress;
  logic            skipLow;
  logic            pendingValid;
  logic [Half-1:0] pendingHalf;
  logic [31:0]     pendingAddress;

  logic [31:0]     wordAddress;
  logic            skipNow;
  logic            pendingNow;
  logic [Half-1:0] lowHalf;
  logic [Half-1:0] highHalf;
  logic            lowCompressed;
  logic            highCompressed;

  logic            firstValid;
  logic [31:0]     firstRaw;
  logic [31:0]     firstAddress;
  logic            upperFree;
  logic            upperSlot;
  logic            upperPending;
  logic [31:0]     upperRaw;
  logic [31:0]     upperAddress;

  // A redirect in the fetch cycle applies to that same word
  assign wordAddress = redirectValid ? {redirectAddress[31:2], 2'b00} : nextAddress;
  assign skipNow     = redirectValid ? redirectAddress[1] : skipLow;
  assign pendingNow  = pendingValid & ~redirectValid;

  assign lowHalf  = fetchWord[Half-1:0];
  assign highHalf = fetchWord[2*Half-1:Half];
  assign lowCompressed  = lowHalf[1:0] != 2'b11;
  assign highCompressed = highHalf[1:0] != 2'b11;

  always_comb begin
    firstValid   = 1'b0;
    firstRaw     = fetchWord;
    firstAddress = wordAddress;
    if (pendingNow) begin // Straddle completes here
      firstValid   = 1'b1;
      firstRaw     = {lowHalf, pendingHalf};
      firstAddress = pendingAddress;
    end else if (!skipNow) begin
      firstValid = 1'b1;
      firstRaw   = lowCompressed ? {{Half{1'b0}}, lowHalf} : fetchWord;
    end
  end

  // Upper half is consumed only by a full instruction starting at the low half
  assign upperFree    = pendingNow | skipNow | lowCompressed;
  assign upperSlot    = upperFree & highCompressed;
  assign upperPending = upperFree & ~highCompressed;
  assign upperRaw     = {{Half{1'b0}}, highHalf};
  assign upperAddress = wordAddress + 32'd2;

  always_ff @(posedge clock) begin
    if (reset) begin
      nextAddress  <= {ResetVector[31:2], 2'b00};
      skipLow      <= ResetVector[1];
      pendingValid <= 1'b0;
      slot0Valid   <= 1'b0;
      slot1Valid   <= 1'b0;
    end else begin
      slot0Valid <= fetchValid & (firstValid | upperSlot);
      slot1Valid <= fetchValid & firstValid & upperSlot;
      if (fetchValid) begin
        nextAddress  <= wordAddress + 32'd4;
        skipLow      <= 1'b0;
        pendingValid <= upperPending;
      end else if (redirectValid) begin
        nextAddress  <= wordAddress;
        skipLow      <= skipNow;
        pendingValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    slot0Raw     <= firstValid ? firstRaw : upperRaw;
    slot0Address <= firstValid ? firstAddress : upperAddress;
    slot1Raw     <= upperRaw;
    slot1Address <= upperAddress;
    if (fetchValid && upperPending) begin
      pendingHalf    <= highHalf;
      pendingAddress <= upperAddress;
    end
  end

endmodule

/* src/FetchExpandUnit.sv */
`timescale 1ns/100ps

module FetchExpandUnit #(
  parameter logic [31:0] ResetVector = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  input  logic        fetchValid,
  input  logic [31:0] fetchWord,
  input  logic        redirectValid,
  input  logic [31:0] redirectAddress,
  output logic        slot0Valid,
  output logic [31:0] slot0Instruction,
  output logic [31:0] slot0Address,
  output logic        slot0Illegal,
  output logic        slot0Unsupported,
  output logic        slot1Valid,
  output logic [31:0] slot1Instruction,
  output logic [31:0] slot1Address,
  output logic        slot1Illegal,
  output logic        slot1Unsupported
);

  logic [31:0] slot0Raw;
  logic [31:0] slot1Raw;

  InstructionAligner #(.ResetVector(ResetVector)) aligner0 (
    .clock(clock), .reset(reset),
    .fetchValid(fetchValid), .fetchWord(fetchWord),
    .redirectValid(redirectValid), .redirectAddress(redirectAddress),
    .slot0Valid(slot0Valid), .slot0Raw(slot0Raw), .slot0Address(slot0Address),
    .slot1Valid(slot1Valid), .slot1Raw(slot1Raw), .slot1Address(slot1Address)
  );

  CompactInstructionsUnit expander0 (
    .targetInstruction(slot0Raw), .resultInstruction(slot0Instruction),
    .isIllegal(slot0Illegal), .isUnsupported(slot0Unsupported)
  );

  CompactInstructionsUnit expander1 (
    .targetInstruction(slot1Raw), .resultInstruction(slot1Instruction),
    .isIllegal(slot1Illegal), .isUnsupported(slot1Unsupported)
  );

endmodule

/* testbench/ClockGen.sv */
`timescale 1ns/100ps

module ClockGen #(
  parameter int HalfPeriod  = 10,
  parameter int ResetCycles = 4
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #HalfPeriod clock = ~clock;
  end

  initial begin
    reset <= 1'b1;
    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    reset <= 1'b0; // Released on a falling edge
  end

endmodule

/* testbench/FetchExpandTb.sv */
`timescale 1ns/100ps

module FetchExpandTb;

  localparam logic [31:0] NopWord = 32'h0000_0013; // addi x0, x0, 0
  localparam logic [1:0]  FlagNone = 2'b00;
  localparam logic [1:0]  FlagIllegal = 2'b10;
  localparam logic [1:0]  FlagUnsupported = 2'b01;
  localparam int          PassthroughCount = 40;
  localparam int          ResetTimeout = 20;

  typedef struct packed {
    logic        redirect;
    logic [31:0] redirectAddress;
    logic [31:0] word;
    logic        valid0;
    logic [31:0] instruction0;
    logic [31:0] address0;
    logic [1:0]  flags0; // {illegal, unsupported}
    logic        valid1;
    logic [31:0] instruction1;
    logic [31:0] address1;
    logic [1:0]  flags1;
  } StimulusRow;

  logic        clock;
  logic        reset;
  logic        fetchValid;
  logic [31:0] fetchWord;
  logic        redirectValid;
  logic [31:0] redirectAddress;
  logic        slot0Valid;
  logic [31:0] slot0Instruction;
  logic [31:0] slot0Address;
  logic        slot0Illegal;
  logic        slot0Unsupported;
  logic        slot1Valid;
  logic [31:0] slot1Instruction;
  logic [31:0] slot1Address;
  logic        slot1Illegal;
  logic        slot1Unsupported;

  StimulusRow rows[$];

  ClockGen clockGen0 (.clock(clock), .reset(reset));

  FetchExpandUnit #(.ResetVector(32'h0000_1000)) dut0 (
    .clock(clock), .reset(reset),
    .fetchValid(fetchValid), .fetchWord(fetchWord),
    .redirectValid(redirectValid), .redirectAddress(redirectAddress),
    .slot0Valid(slot0Valid), .slot0Instruction(slot0Instruction),
    .slot0Address(slot0Address), .slot0Illegal(slot0Illegal),
    .slot0Unsupported(slot0Unsupported),
    .slot1Valid(slot1Valid), .slot1Instruction(slot1Instruction),
    .slot1Address(slot1Address), .slot1Illegal(slot1Illegal),
    .slot1Unsupported(slot1Unsupported)
  );

  task automatic compareValue(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("tests failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic addRow(input logic redirect, input logic [31:0] target,
                        input logic [31:0] word, input logic valid0,
                        input logic [31:0] instruction0, input logic [31:0] address0,
                        input logic [1:0] flags0, input logic valid1,
                        input logic [31:0] instruction1, input logic [31:0] address1,
                        input logic [1:0] flags1);
    rows.push_back({redirect, target, word, valid0, instruction0, address0, flags0,
                    valid1, instruction1, address1, flags1});
  endtask

  // Compressed instruction in the low half, C.NOP above it
  task automatic addExpansion(input logic [15:0] lowHalf, input logic [31:0] expected,
                              input logic [31:0] address);
    addRow(1'b0, 32'd0, {16'h0001, lowHalf}, 1'b1, expected, address, FlagNone,
           1'b1, NopWord, address + 32'd2, FlagNone);
  endtask

  task automatic addFlagged(input logic [15:0] lowHalf, input logic [1:0] flags,
                            input logic [31:0] address);
    addRow(1'b0, 32'd0, {16'h0001, lowHalf}, 1'b1, NopWord, address, flags,
           1'b1, NopWord, address + 32'd2, FlagNone);
  endtask

  task automatic buildTable();
    logic [31:0] word;
    logic [31:0] address;
    addExpansion(16'h0800, 32'h0101_0413, 32'h1000); // C.ADDI4SPN x8, 16
    addExpansion(16'h4144, 32'h0045_2483, 32'h1004); // C.LW x9, 4(x10)
    addExpansion(16'hC60C, 32'h00B6_2423, 32'h1008); // C.SW x11, 8(x12)
    addExpansion(16'h1575, 32'hFFD5_0513, 32'h100C); // C.ADDI x10, -3
    addExpansion(16'h2021, 32'h0080_00EF, 32'h1010); // C.JAL +8
    addExpansion(16'h429D, 32'h0070_0293, 32'h1014); // C.LI x5, 7
    addExpansion(16'h6105, 32'h0201_0113, 32'h1018); // C.ADDI16SP 32
    addExpansion(16'h6185, 32'h0000_11B7, 32'h101C); // C.LUI x3, 1
    addExpansion(16'h8815, 32'h0054_7413, 32'h1020); // C.ANDI x8, 5
    addExpansion(16'h8C89, 32'h40A4_84B3, 32'h1024); // C.SUB x9, x10
    addExpansion(16'h8CA9, 32'h00A4_C4B3, 32'h1028); // C.XOR
    addExpansion(16'h8CC9, 32'h00A4_E4B3, 32'h102C); // C.OR
    addExpansion(16'h8CE9, 32'h00A4_F4B3, 32'h1030); // C.AND
    addExpansion(16'hBFF5, 32'hFFDF_F06F, 32'h1034); // C.J -4
    addExpansion(16'hDC65, 32'hFE04_0CE3, 32'h1038); // C.BEQZ x8, -8
    addExpansion(16'hE099, 32'h0004_9363, 32'h103C); // C.BNEZ x9, +6
    addExpansion(16'h929A, 32'h0062_82B3, 32'h1040); // C.ADD x5, x6
    // C.LI low and C.ADD high in one word
    addRow(1'b0, 32'd0, 32'h929A_429D, 1'b1, 32'h0070_0293, 32'h1044, FlagNone,
           1'b1, 32'h0062_82B3, 32'h1046, FlagNone);
    // addi x7, x0, 0x123 straddles two words
    addRow(1'b0, 32'd0, 32'h0393_429D, 1'b1, 32'h0070_0293, 32'h1048, FlagNone,
           1'b0, 32'd0, 32'd0, FlagNone);
    addRow(1'b0, 32'd0, 32'h0001_1230, 1'b1, 32'h1230_0393, 32'h104A, FlagNone,
           1'b1, NopWord, 32'h104E, FlagNone);
    // Odd redirect skips the C.LW in the low half
    addRow(1'b1, 32'h2002, 32'h1575_4144, 1'b1, 32'hFFD5_0513, 32'h2002, FlagNone,
           1'b0, 32'd0, 32'd0, FlagNone);
    addExpansion(16'h8C89, 32'h40A4_84B3, 32'h2004);
    addRow(1'b0, 32'd0, 32'h0000_0000, 1'b1, NopWord, 32'h2008, FlagIllegal,
           1'b1, NopWord, 32'h200A, FlagIllegal);
    addFlagged(16'h6101, FlagIllegal, 32'h200C);     // C.ADDI16SP with zero immediate
    addFlagged(16'h9C41, FlagIllegal, 32'h2010);     // Reserved CA encoding
    addFlagged(16'h2000, FlagUnsupported, 32'h2014); // C.FLD
    addFlagged(16'h829A, FlagUnsupported, 32'h2018); // C.MV
    addFlagged(16'h4292, FlagUnsupported, 32'h201C); // C.LWSP
    // Odd redirect onto a full instruction
    addRow(1'b1, 32'h3002, 32'h0393_4144, 1'b0, 32'd0, 32'd0, FlagNone,
           1'b0, 32'd0, 32'd0, FlagNone);
    addRow(1'b0, 32'd0, 32'h0001_1230, 1'b1, 32'h1230_0393, 32'h3002, FlagNone,
           1'b1, NopWord, 32'h3006, FlagNone);
    address = 32'h0000_4000;
    for (int k = 0; k < PassthroughCount; k++) begin
      word = $urandom | 32'h0000_0003;
      addRow(k == 0, 32'h0000_4000, word, 1'b1, word, address, FlagNone,
             1'b0, 32'd0, 32'd0, FlagNone);
      address = address + 32'd4;
    end
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
      if (cycles > ResetTimeout) begin
        $display("Timeout: reset was not released within %0d cycles", ResetTimeout);
        $display("tests failed");
        $fatal(1, "reset timeout");
      end
    end while (reset);
  endtask

  task automatic checkRow(input StimulusRow row, input int index);
    compareValue($sformatf("row %0d slot0 valid", index), {31'd0, slot0Valid},
                 {31'd0, row.valid0});
    if (row.valid0) begin
      compareValue($sformatf("row %0d slot0 instruction", index), slot0Instruction,
                   row.instruction0);
      compareValue($sformatf("row %0d slot0 address", index), slot0Address, row.address0);
      compareValue($sformatf("row %0d slot0 flags", index),
                   {30'd0, slot0Illegal, slot0Unsupported}, {30'd0, row.flags0});
    end
    compareValue($sformatf("row %0d slot1 valid", index), {31'd0, slot1Valid},
                 {31'd0, row.valid1});
    if (row.valid1) begin
      compareValue($sformatf("row %0d slot1 instruction", index), slot1Instruction,
                   row.instruction1);
      compareValue($sformatf("row %0d slot1 address", index), slot1Address, row.address1);
      compareValue($sformatf("row %0d slot1 flags", index),
                   {30'd0, slot1Illegal, slot1Unsupported}, {30'd0, row.flags1});
    end
  endtask

  initial begin
    int unsigned seedResult;
    fetchValid = 1'b0;
    fetchWord = 32'd0;
    redirectValid = 1'b0;
    redirectAddress = 32'd0;
    seedResult = $urandom(32'h5b6e);
    buildTable();
    waitForReset();
    compareValue("slot0 valid after reset", {31'd0, slot0Valid}, 32'd0);
    compareValue("slot1 valid after reset", {31'd0, slot1Valid}, 32'd0);
    for (int i = 0; i < rows.size(); i++) begin
      redirectValid = rows[i].redirect;
      redirectAddress = rows[i].redirectAddress;
      fetchValid = 1'b1;
      fetchWord = rows[i].word;
      @(negedge clock);
      checkRow(rows[i], i); // Slots follow the fetch by one cycle
    end
    fetchValid = 1'b0;
    redirectValid = 1'b0;
    @(negedge clock);
    compareValue("slot0 valid when idle", {31'd0, slot0Valid}, 32'd0);
    compareValue("slot1 valid when idle", {31'd0, slot1Valid}, 32'd0);
    $display("all tests passed");
    $finish;
  end

endmodule

/* verilog.f */
src/RvcPkg.sv
src/CompactInstructionsUnit.sv
src/InstructionAligner.sv
src/FetchExpandUnit.sv
testbench/ClockGen.sv
testbench/FetchExpandTb.sv

/* Makefile */
SOURCES = src/RvcPkg.sv src/CompactInstructionsUnit.sv src/InstructionAligner.sv \
          src/FetchExpandUnit.sv testbench/ClockGen.sv testbench/FetchExpandTb.sv

.PHONY: all run clean

all: obj_dir/VFetchExpandTb

# Rebuilt only when a source or the file list changes
obj_dir/VFetchExpandTb: verilog.f $(SOURCES)
	verilator --binary --timing --top-module FetchExpandTb -f verilog.f -o VFetchExpandTb

# The exit status of the binary is the test result
run: obj_dir/VFetchExpandTb
	./obj_dir/VFetchExpandTb

clean:
	rm -rf obj_dir
